/* design/mem_stage_pkg.sv */
package mem_stage_pkg;

    localparam int addr_w    = 32;
    localparam int data_w    = 32;
    localparam int num_lines = 16;
    localparam int index_w   = 4;
    localparam int tag_w     = 26;   // addr_w - index_w - 2

    localparam logic [1:0] axi_resp_okay = 2'b00;

    // code 3 is reserved and handled as dword
    typedef enum logic [1:0] {
        size_byte  = 2'd0,
        size_word  = 2'd1,
        size_dword = 2'd2
    } mem_size_e;

    typedef struct packed {
        logic [addr_w-1:0] eff_addr;
        mem_size_e         size;
        logic              is_load;
        logic              seg_fault;
        logic              align_fault;
        logic              ie_in;
        logic [1:0]        ie_type_hi;   // upper exception type bits, passed along
    } mem_req_t;

    function automatic logic [2:0] size_bytes(input mem_size_e size);
        case (size)
            size_byte: return 3'd1;
            size_word: return 3'd2;
            default:   return 3'd4;
        endcase
    endfunction

endpackage

/* design/cache_fill_if.sv */
`timescale 1ns/1ps

interface cache_fill_if import mem_stage_pkg::*; ();

    logic              req;     // held until done
    logic [addr_w-1:0] addr;    // word aligned
    logic              gnt;     // address phase accepted
    logic              done;    // one cycle, rdata and err valid
    logic [data_w-1:0] rdata;
    logic [1:0]        err;     // raw response code

    modport cache (
        output req, addr,
        input  gnt, done, rdata, err
    );

    modport master (
        input  req, addr,
        output gnt, done, rdata, err
    );

endinterface

/* design/mem_addr_gen.sv */
`timescale 1ns/1ps

module mem_addr_gen import mem_stage_pkg::*; (
    input  logic [1:0]        opsize,
    input  logic [2:0]        size_ovr,
    input  logic              is_push,
    input  logic              is_load,
    input  logic [addr_w-1:0] mem_addr,
    input  logic [addr_w-1:0] seg_lim,
    input  logic              ie_in,
    input  logic [3:0]        ie_type_in,
    output mem_req_t          req
);

    mem_size_e         size;
    logic [2:0]        nbytes;
    logic [addr_w-1:0] addr;
    logic [addr_w:0]   last_byte;   // one extra bit catches wrap
    logic [2:0]        end_off;
    logic              checked;

    // override wins when any bit is set
    always_comb begin
        if (size_ovr[0]) begin
            size = size_byte;
        end else if (size_ovr[1]) begin
            size = size_word;
        end else if (size_ovr[2]) begin
            size = size_dword;
        end else if (opsize == 2'd3) begin
            size = size_dword;   // reserved code
        end else begin
            size = mem_size_e'(opsize);
        end
    end

    assign nbytes = size_bytes(size);

    // push pre-decrements the stack pointer
    assign addr = is_push ? (mem_addr - addr_w'(nbytes)) : mem_addr;

    assign last_byte = {1'b0, addr} + (addr_w + 1)'(nbytes - 3'd1);
    assign end_off   = {1'b0, addr[1:0]} + (nbytes - 3'd1);

    assign checked = is_load | is_push;

    always_comb begin
        req             = '0;
        req.eff_addr    = addr;
        req.size        = size;
        req.is_load     = is_load;
        req.seg_fault   = checked && (last_byte > {1'b0, seg_lim});
        req.align_fault = checked && end_off[2];   // spills into next word
        req.ie_in       = ie_in;
        req.ie_type_hi  = ie_type_in[3:2];
    end

    // decode upstream is expected to send at most one override bit
    always_comb begin
        if (!$isunknown(size_ovr)) begin
            assert ($onehot0(size_ovr))
                else $error("size_ovr not one-hot: %b", size_ovr);
        end
    end

endmodule

/* design/dcache.sv */
`timescale 1ns/1ps

module dcache import mem_stage_pkg::*; (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              accept,
    input  mem_req_t          req,
    cache_fill_if.cache       fill,
    output logic              busy,
    output logic              hit_valid,
    output logic [data_w-1:0] load_data
);

    typedef enum logic [1:0] {
        st_idle,
        st_fill_ar,
        st_fill_r
    } fill_state_e;

    fill_state_e state;

    logic [tag_w-1:0]  tag_mem  [num_lines];
    logic [data_w-1:0] data_mem [num_lines];
    logic [num_lines-1:0] line_valid;

    logic [index_w-1:0] idx;
    logic [index_w-1:0] miss_idx;
    logic [tag_w-1:0]   tag;
    logic [tag_w-1:0]   miss_tag;
    logic [1:0]         miss_off;
    mem_size_e          miss_size;
    logic [data_w-1:0]  data_q;
    logic               lookup;
    logic               hit;
    logic               fill_ok;

    // pick the addressed bytes and zero-extend
    function automatic logic [data_w-1:0] align_load(
        input logic [data_w-1:0] word,
        input logic [1:0]        off,
        input mem_size_e         size
    );
        logic [data_w-1:0] shifted;
        shifted = word >> {off, 3'b000};
        case (size)
            size_byte: return {{(data_w - 8){1'b0}}, shifted[7:0]};
            size_word: return {{(data_w - 16){1'b0}}, shifted[15:0]};
            default:   return shifted;
        endcase
    endfunction

    assign idx     = req.eff_addr[index_w+1:2];
    assign tag     = req.eff_addr[addr_w-1:index_w+2];
    assign lookup  = accept && req.is_load && !req.seg_fault && !req.align_fault;
    assign hit     = line_valid[idx] && (tag_mem[idx] == tag);
    assign fill_ok = (fill.err == axi_resp_okay);

    assign busy      = (state != st_idle);
    assign fill.req  = busy;
    assign fill.addr = {miss_tag, miss_idx, 2'b00};
    assign load_data = data_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= st_idle;
            line_valid <= '0;
            hit_valid  <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (lookup && !hit) begin
                        state <= st_fill_ar;
                    end
                end
                st_fill_ar: begin
                    if (fill.gnt) begin
                        state <= st_fill_r;
                    end
                end
                st_fill_r: begin
                    if (fill.done) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase

            if (accept) begin
                hit_valid <= lookup && hit;   // miss waits for the fill
            end else if (fill.done) begin
                hit_valid <= 1'b1;
            end

            if (fill.done && fill_ok) begin
                line_valid[miss_idx] <= 1'b1;   // error leaves the line alone
            end
        end
    end

    always_ff @(posedge clk) begin
        if (lookup && !hit) begin
            miss_tag  <= tag;
            miss_idx  <= idx;
            miss_off  <= req.eff_addr[1:0];
            miss_size <= req.size;
        end

        if (accept) begin
            data_q <= (lookup && hit) ? align_load(data_mem[idx], req.eff_addr[1:0], req.size)
                                      : '0;
        end else if (fill.done) begin
            data_q <= fill_ok ? align_load(fill.rdata, miss_off, miss_size) : '0;
        end

        if (fill.done && fill_ok) begin
            tag_mem[miss_idx]  <= miss_tag;
            data_mem[miss_idx] <= fill.rdata;
        end
    end

    // stall logic in the top level must hold off new work during a fill
    assert property (@(posedge clk) disable iff (!arst_n) busy |-> !accept)
        else $error("accept while cache busy");

endmodule

/* design/axil_read_master.sv */
`timescale 1ns/1ps

module axil_read_master import mem_stage_pkg::*; (
    input  logic              clk,
    input  logic              arst_n,
    cache_fill_if.master      fill,
    output logic [addr_w-1:0] araddr,
    output logic              arvalid,
    output logic              rready,
    input  logic              arready,
    input  logic              rvalid,
    input  logic [data_w-1:0] rdata,
    input  logic [1:0]        rresp
);

    typedef enum logic [1:0] {
        st_idle,
        st_addr,
        st_data
    } rd_state_e;

    rd_state_e         state;
    logic [addr_w-1:0] araddr_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: if (fill.req) state <= st_addr;
                st_addr: if (arready) state <= st_data;
                st_data: if (rvalid) state <= st_idle;
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && fill.req) begin
            araddr_q <= fill.addr;
        end
    end

    assign araddr  = araddr_q;
    assign arvalid = (state == st_addr);
    assign rready  = (state == st_data);   // only after AR completes

    assign fill.gnt   = arvalid && arready;
    assign fill.done  = rready && rvalid;
    assign fill.rdata = rdata;
    assign fill.err   = rresp;

    assert property (@(posedge clk) disable iff (!arst_n)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else $error("AR request withdrawn before arready");

endmodule

/* design/mem_stage.sv */
`timescale 1ns/1ps

module mem_stage import mem_stage_pkg::*; (
    input  logic              clk,
    input  logic              arst_n,

    input  logic              valid_in,
    input  logic              fwd_stall,
    input  logic [1:0]        opsize,
    input  logic [2:0]        size_ovr,
    input  logic              is_push,
    input  logic              is_load,
    input  logic [addr_w-1:0] mem_addr,
    input  logic [addr_w-1:0] seg_lim,
    input  logic              ie_in,
    input  logic [3:0]        ie_type_in,

    output logic              stall,
    output logic              valid_out,
    output logic [addr_w-1:0] eff_addr,
    output logic [data_w-1:0] load_data,
    output logic              ie_out,
    output logic [3:0]        ie_type,

    output logic [addr_w-1:0] araddr,
    output logic              arvalid,
    output logic              rready,
    input  logic              arready,
    input  logic              rvalid,
    input  logic [data_w-1:0] rdata,
    input  logic [1:0]        rresp
);

    mem_req_t req;
    logic     accept;
    logic     busy;
    logic     hit_valid;
    logic     fault;
    logic     out_valid_q;
    logic     cache_ld_q;   // result waits on the cache

    cache_fill_if fill_if ();

    mem_addr_gen i_addr_gen (
        .opsize     (opsize),
        .size_ovr   (size_ovr),
        .is_push    (is_push),
        .is_load    (is_load),
        .mem_addr   (mem_addr),
        .seg_lim    (seg_lim),
        .ie_in      (ie_in),
        .ie_type_in (ie_type_in),
        .req        (req)
    );

    dcache i_dcache (
        .clk       (clk),
        .arst_n    (arst_n),
        .accept    (accept),
        .req       (req),
        .fill      (fill_if.cache),
        .busy      (busy),
        .hit_valid (hit_valid),
        .load_data (load_data)
    );

    axil_read_master i_axil_rd (
        .clk     (clk),
        .arst_n  (arst_n),
        .fill    (fill_if.master),
        .araddr  (araddr),
        .arvalid (arvalid),
        .rready  (rready),
        .arready (arready),
        .rvalid  (rvalid),
        .rdata   (rdata),
        .rresp   (rresp)
    );

    assign stall  = fwd_stall | busy;
    assign accept = valid_in & ~stall;
    assign fault  = req.seg_fault | req.align_fault;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid_q <= 1'b0;
            cache_ld_q  <= 1'b0;
        end else if (accept) begin
            out_valid_q <= 1'b1;
            cache_ld_q  <= req.is_load & ~fault;
        end else if (valid_out && !fwd_stall) begin
            out_valid_q <= 1'b0;   // delivered
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            eff_addr <= req.eff_addr;
            ie_out   <= req.ie_in | fault;
            ie_type  <= {req.ie_type_hi, req.align_fault, req.seg_fault};
        end
    end

    assign valid_out = out_valid_q & (~cache_ld_q | hit_valid);

    // back-pressure must freeze the whole result
    assert property (@(posedge clk) disable iff (!arst_n)
        valid_out && fwd_stall |=> valid_out && $stable(eff_addr) && $stable(load_data))
        else $error("result changed under fwd_stall");

endmodule

/* sim/mem_checker.sv */
`timescale 1ns/1ps

module mem_checker #(
    parameter logic [31:0] pattern_key = 32'h5a5a_c3c3,
    parameter logic [31:0] err_lo      = 32'h0000_10e0,
    parameter logic [31:0] err_hi      = 32'h0000_10ff
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        valid_in,
    input  logic        fwd_stall,
    input  logic [1:0]  opsize,
    input  logic [2:0]  size_ovr,
    input  logic        is_push,
    input  logic        is_load,
    input  logic [31:0] mem_addr,
    input  logic [31:0] seg_lim,
    input  logic        ie_in,
    input  logic [3:0]  ie_type_in,
    input  logic        stall,
    input  logic        valid_out,
    input  logic [31:0] eff_addr,
    input  logic [31:0] load_data,
    input  logic        ie_out,
    input  logic [3:0]  ie_type,
    input  logic        arvalid,
    input  logic        arready,
    input  logic        rvalid,
    input  logic        rready,
    output int          checks,
    output int          errors,
    output int          pending
);

    typedef struct packed {
        logic [31:0] eff_addr;
        logic [31:0] data;
        logic        ie_out;
        logic [3:0]  ie_type;
        logic [31:0] ar_count;   // total AR handshakes once this result is out
    } result_t;

    result_t     exp_q[$];
    logic [25:0] model_tag [16];
    logic [15:0] model_valid;
    logic [31:0] ar_seen;
    logic [31:0] r_seen;   // R handshakes
    logic [31:0] ar_expected;

    // little-endian bytes starting at off, zero above
    function automatic logic [31:0] pick_bytes(input logic [31:0] word, input logic [1:0] off,
                                               input logic [2:0] n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < 4; i++) begin
            if (i < int'(n)) begin
                value[8*i +: 8] = word[8*(int'(off) + i) +: 8];
            end
        end
        return value;
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("Fail at %0t: %s got 0x%h expected 0x%h", $time, name, got, want);
        end
    endtask

    task automatic model_accept();
        result_t     want;
        logic [32:0] count;
        logic [32:0] last;
        logic        checked;
        logic        seg;
        logic        align;
        logic [3:0]  idx;
        logic [31:0] word;
        if (size_ovr[0]) count = 33'd1;
        else if (size_ovr[1]) count = 33'd2;
        else if (size_ovr[2]) count = 33'd4;
        else count = (opsize == 2'd0) ? 33'd1 : (opsize == 2'd1) ? 33'd2 : 33'd4;
        want.eff_addr = is_push ? mem_addr - count[31:0] : mem_addr;
        checked = is_load || is_push;
        last    = {1'b0, want.eff_addr} + count - 33'd1;
        seg     = checked && (last > {1'b0, seg_lim});
        align   = checked && (({31'd0, want.eff_addr[1:0]} + count) > 33'd4);
        want.data = '0;
        if (is_load && !seg && !align) begin
            idx  = want.eff_addr[5:2];
            word = {2'b00, want.eff_addr[31:2]} ^ pattern_key;
            if (!(model_valid[idx] && model_tag[idx] == want.eff_addr[31:6])) begin
                ar_expected = ar_expected + 32'd1;
                if (want.eff_addr >= err_lo && want.eff_addr <= err_hi) begin
                    word = '0;   // line keeps its old contents
                end else begin
                    model_valid[idx] = 1'b1;
                    model_tag[idx]   = want.eff_addr[31:6];
                end
            end
            want.data = pick_bytes(word, want.eff_addr[1:0], count[2:0]);
        end
        want.ie_out   = ie_in | seg | align;
        want.ie_type  = {ie_type_in[3:2], align, seg};
        want.ar_count = ar_expected;
        exp_q.push_back(want);
    endtask

    task automatic check_result();
        result_t want;
        if (exp_q.size() == 0) begin
            errors++;
            $display("Error at %0t: result delivered with no instruction pending", $time);
        end else begin
            want = exp_q.pop_front();
            compare("eff_addr", eff_addr, want.eff_addr);
            compare("load_data", load_data, want.data);
            compare("ie_out", {31'd0, ie_out}, {31'd0, want.ie_out});
            compare("ie_type", {28'd0, ie_type}, {28'd0, want.ie_type});
            compare("arvalid/arready handshakes", ar_seen, want.ar_count);
        end
    endtask

    always @(posedge clk) begin
        if (!arst_n) begin
            exp_q.delete();
            model_valid = '0;
            ar_seen     = '0;
            r_seen      = '0;
            ar_expected = '0;
            checks      = 0;
            errors      = 0;
        end else begin
            if (rready && ar_seen == r_seen) begin
                errors++;
                $display("Error at %0t: rready high before the AR handshake", $time);
            end
            if (arvalid && arready) ar_seen = ar_seen + 32'd1;
            if (rvalid && rready) r_seen = r_seen + 32'd1;
            if (fwd_stall && !stall) begin
                errors++;
                $display("Error at %0t: stall is low while fwd_stall is high", $time);
            end
            if (valid_out && !fwd_stall) check_result();   // delivered
            if (valid_in && !stall) model_accept();
        end
        pending = exp_q.size();
    end

endmodule

/* sim/tb_mem_stage.sv */
`timescale 1ns/1ps

module tb_mem_stage;

    localparam int          num_tests      = 6;
    localparam int          ops_per_test   = 64;
    localparam int          num_ops        = num_tests * ops_per_test;
    localparam int          timeout_cycles = num_ops * 12 + 200;
    localparam logic [31:0] pattern_key    = 32'h5a5a_c3c3;
    localparam logic [31:0] err_lo         = 32'h0000_10e0;   // SLVERR region
    localparam logic [31:0] err_hi         = 32'h0000_10ff;

    logic        clk = 1'b0;
    logic        arst_n;
    logic        valid_in, fwd_stall, is_push, is_load, ie_in;
    logic [1:0]  opsize;
    logic [2:0]  size_ovr;
    logic [31:0] mem_addr, seg_lim;
    logic [3:0]  ie_type_in;
    logic        stall, valid_out, ie_out;
    logic [31:0] eff_addr, load_data;
    logic [3:0]  ie_type;
    logic [31:0] araddr, rdata;
    logic        arvalid, rready, arready, rvalid;
    logic [1:0]  rresp;
    int          checks, errors, pending;
    integer      stim_seed, resp_seed, bp_seed;
    logic        bp_on;

    always #4 clk = ~clk;

    mem_stage i_dut (.*);

    mem_checker #(
        .pattern_key (pattern_key),
        .err_lo      (err_lo),
        .err_hi      (err_hi)
    ) i_checker (.*);

    function automatic logic [2:0] pick_override(input logic [1:0] sel);
        case (sel)
            2'd0:    return 3'b000;
            2'd1:    return 3'b001;
            2'd2:    return 3'b010;
            default: return 3'b100;
        endcase
    endfunction

    function automatic string test_name(input int t);
        case (t)
            0:       return "size";
            1:       return "push";
            2:       return "seg_limit";
            3:       return "align";
            4:       return "cache";
            default: return "back_pressure";
        endcase
    endfunction

    // valid_in is already high, so a low stall at the edge means taken
    task automatic wait_accept();
        logic taken;
        taken = 1'b0;
        while (!taken) begin
            @(posedge clk);
            taken = !stall;
        end
    endtask

    task automatic run_test(input int t);
        int          checks_at_start;
        int          errors_at_start;
        logic [31:0] r;
        checks_at_start = checks;
        errors_at_start = errors;
        bp_on = (t == 5);
        for (int i = 0; i < ops_per_test; i++) begin
            r = $random(stim_seed);
            @(negedge clk);
            valid_in   = 1'b1;
            opsize     = r[1:0];
            size_ovr   = pick_override(r[3:2]);
            is_push    = 1'b0;
            is_load    = 1'b1;
            mem_addr   = 32'h0000_1000 + {24'd0, r[15:8]};
            seg_lim    = 32'hffff_ffff;
            ie_in      = r[24];
            ie_type_in = r[23:20];
            case (t)
                1: begin
                    is_push  = 1'b1;
                    is_load  = 1'b0;
                    mem_addr = 32'h0000_8000 + {24'd0, r[15:8]};
                end
                2: begin
                    is_push = r[4];
                    is_load = !r[4];
                    seg_lim = mem_addr + {29'd0, r[18:16]} - 32'd4;   // limit around the access
                end
                4: mem_addr = 32'h0000_1000 + (r[7:6] == 2'd3 ? 32'h0000_00c0 : 32'h0)
                              + {26'd0, r[13:10], 2'b00};
                5: begin
                    is_push = (r[5:4] == 2'd0);
                    is_load = r[5];
                    seg_lim = r[7] ? 32'hffff_ffff : mem_addr + 32'd2;
                end
                default: ;
            endcase
            wait_accept();
            if (r[31:29] == 3'd0) begin
                @(negedge clk);
                valid_in = 1'b0;
                repeat (r[28:27]) @(negedge clk);
            end
        end
        @(negedge clk);
        valid_in = 1'b0;
        bp_on    = 1'b0;
        while (pending != 0) begin
            @(negedge clk);
        end
        $display("test %0d %s: %0d checks, %0d errors", t, test_name(t),
                 checks - checks_at_start, errors - errors_at_start);
    endtask

    initial begin
        stim_seed  = 32'h1a43_8a7d;
        resp_seed  = $random(stim_seed);
        bp_seed    = $random(stim_seed);
        arst_n     = 1'b0;
        valid_in   = 1'b0;
        opsize     = 2'd0;
        size_ovr   = 3'd0;
        is_push    = 1'b0;
        is_load    = 1'b0;
        mem_addr   = '0;
        seg_lim    = '0;
        ie_in      = 1'b0;
        ie_type_in = 4'd0;
        bp_on      = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        for (int t = 0; t < num_tests; t++) begin
            run_test(t);
        end
        $display("%0d tests run, %0d checks, %0d errors", num_tests, checks, errors);
        if (errors == 0 && pending == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // AXI4-Lite slave memory with 0 to 3 cycle waits
    initial begin : axi_memory
        logic [31:0] addr;
        integer      wait_cycles;
        arready = 1'b0;
        rvalid  = 1'b0;
        rdata   = '0;
        rresp   = 2'b00;
        forever begin
            @(negedge clk);
            if (arvalid) begin
                wait_cycles = $random(resp_seed) & 3;
                repeat (wait_cycles) @(negedge clk);
                arready = 1'b1;
                @(posedge clk);   // AR handshake
                addr = araddr;
                @(negedge clk);
                arready     = 1'b0;
                wait_cycles = $random(resp_seed) & 3;
                repeat (wait_cycles) @(negedge clk);
                rvalid = 1'b1;
                rdata  = {2'b00, addr[31:2]} ^ pattern_key;
                rresp  = (addr >= err_lo && addr <= err_hi) ? 2'b10 : 2'b00;
                @(posedge clk);
                while (!rready) begin   // hold R until taken
                    @(posedge clk);
                end
                @(negedge clk);
                rvalid = 1'b0;
            end
        end
    end

    initial begin : back_pressure
        integer span;
        fwd_stall = 1'b0;
        span      = 0;
        forever begin
            @(negedge clk);
            if (!bp_on) begin
                fwd_stall = 1'b0;
            end else if (span == 0) begin
                fwd_stall = !fwd_stall;
                span      = ($random(bp_seed) & 7) + 1;
            end else begin
                span = span - 1;
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < timeout_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: run did not finish within %0d cycles", timeout_cycles);
        $display("Test failures found");
        $finish;
    end

endmodule

/* mem_stage.f */
design/mem_stage_pkg.sv
design/cache_fill_if.sv
design/mem_addr_gen.sv
design/dcache.sv
design/axil_read_master.sv
design/mem_stage.sv
sim/mem_checker.sv
sim/tb_mem_stage.sv

/* Makefile */
sim:
	verilator --binary --timing --assert --top-module tb_mem_stage -f mem_stage.f -o tb_mem_stage
	./obj_dir/tb_mem_stage | tee sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
